//--- Bender.yml
package:
  name: tetrisCore

sources:
  - hw/tetrisPkg.sv
  - hw/pieceQueue.sv
  - hw/dropTimer.sv
  - hw/moveDown.sv
  - hw/lineClear.sv
  - hw/gameControl.sv
  - hw/tetrisTop.sv
  - target: test
    files:
      - verif/tetrisTop_props.sv
      - verif/tetrisTb.sv

//--- hw/dropTimer.sv
`timescale 1ns/100ps

module dropTimer (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic spawn,
    output logic tick
);

    logic [tetrisPkg::DropCntBits-1:0] count;
    logic                              atEnd;

    assign atEnd = (count == tetrisPkg::DropCntBits'(tetrisPkg::DropPeriod - 1));
    assign tick  = run && atEnd;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (spawn) begin
            count <= '0;  // New piece gets a full first interval
        end else if (run) begin
            if (atEnd) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- hw/gameControl.sv
`timescale 1ns/100ps

module gameControl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 headValid,
    output logic                 pop,
    output logic                 spawn,
    input  logic                 landed,
    input  logic                 blocked,
    input  tetrisPkg::boardArray overlay,
    input  logic                 clearDone,
    input  logic [2:0]           clearCount,
    input  tetrisPkg::boardArray clearedBoard,
    output logic                 clearStart,
    output tetrisPkg::boardArray settled,
    output logic                 reportValid,
    output logic [2:0]           reportCount,
    input  logic                 reportCredit,
    output logic                 gameOver,
    output logic                 timerRun
);

    typedef enum logic [2:0] {
        StIdle,
        StSpawn,
        StFall,
        StClear,
        StReport,
        StOver
    } ctrlState;

    ctrlState                            state;
    logic [tetrisPkg::ReportCntBits-1:0] credits;

    assign pop         = (state == StIdle) && headValid;
    assign spawn       = pop;  // Piece is taken and placed in one step
    assign timerRun    = (state == StSpawn) || (state == StFall);
    assign reportValid = (state == StReport) && (credits != '0);
    assign gameOver    = (state == StOver);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= StIdle;
            settled     <= '0;
            clearStart  <= 1'b0;
            reportCount <= '0;
        end else begin
            clearStart <= 1'b0;
            case (state)
                StIdle: begin
                    if (pop) begin
                        state <= StSpawn;
                    end
                end
                StSpawn: begin
                    if (blocked) begin
                        state <= StOver;  // No room for the new piece
                    end else begin
                        state <= StFall;
                    end
                end
                StFall: begin
                    if (landed) begin
                        settled    <= overlay;
                        clearStart <= 1'b1;  // lineClear sees the new settled board
                        state      <= StClear;
                    end
                end
                StClear: begin
                    if (clearDone) begin
                        settled     <= clearedBoard;
                        reportCount <= clearCount;
                        state       <= StReport;
                    end
                end
                StReport: begin
                    if (reportValid) begin
                        state <= StIdle;
                    end
                end
                StOver:  state <= StOver;  // Sticky until reset
                default: state <= StIdle;
            endcase
        end
    end

    // Report credit counter
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            credits <= tetrisPkg::ReportCntBits'(tetrisPkg::ReportCredits);
        end else begin
            case ({reportValid, reportCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- hw/lineClear.sv
`timescale 1ns/100ps

module lineClear (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  tetrisPkg::boardArray boardIn,
    output tetrisPkg::boardArray boardOut,
    output logic [2:0]           clearCount,
    output logic                 clearDone
);

    tetrisPkg::boardArray work;
    tetrisPkg::rowIndex   scanRow;
    logic                 busy;
    logic                 rowFull;

    assign rowFull  = &work[scanRow];
    assign boardOut = work;

    // Working copy of the board
    always_ff @(posedge clk) begin
        if (start) begin
            work <= boardIn;
        end else if (busy && rowFull) begin
            for (int r = 1; r < tetrisPkg::PlayRows; r++) begin
                if (r <= int'(scanRow)) begin
                    work[r] <= work[r-1];  // Drop everything above the full row
                end
            end
            work[0] <= '0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            scanRow    <= '0;
            busy       <= 1'b0;
            clearCount <= '0;
            clearDone  <= 1'b0;
        end else begin
            clearDone <= 1'b0;
            if (start) begin
                scanRow    <= tetrisPkg::rowIndex'(tetrisPkg::PlayRows - 1);
                busy       <= 1'b1;
                clearCount <= '0;
            end else if (busy) begin
                if (rowFull) begin
                    clearCount <= clearCount + 3'd1;  // Rescan the same row next
                end else if (scanRow == '0) begin
                    busy      <= 1'b0;
                    clearDone <= 1'b1;
                end else begin
                    scanRow <= scanRow - 5'd1;
                end
            end
        end
    end

endmodule

//--- hw/moveDown.sv
`timescale 1ns/100ps

module moveDown (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spawn,
    input  logic                 tick,
    input  tetrisPkg::pieceKind  pieceType,
    input  tetrisPkg::colIndex   pieceCol,
    input  tetrisPkg::boardArray settled,
    output tetrisPkg::boardArray overlay,
    output logic                 landed,
    output logic                 blocked
);

    tetrisPkg::rowIndex   blockY;
    tetrisPkg::pieceKind  curType;
    tetrisPkg::colIndex   curCol;
    logic                 active;    // A piece is on the board and falling
    tetrisPkg::boardArray curMask;
    tetrisPkg::boardArray nextMask;
    logic                 canMove;

    // Cell mask of a shape anchored at (row, col)
    function automatic tetrisPkg::boardArray shapeMask(
        input tetrisPkg::pieceKind kind,
        input tetrisPkg::colIndex  col,
        input tetrisPkg::rowIndex  row
    );
        logic [3:0][2:0]      pattern;  // pattern[rowOffset][colOffset]
        tetrisPkg::boardArray mask;
        int                   cellRow;
        int                   cellCol;

        mask = '0;
        case (kind)
            tetrisPkg::PieceLine:   pattern = {3'b001, 3'b001, 3'b001, 3'b001};
            tetrisPkg::PieceSquare: pattern = {3'b000, 3'b000, 3'b011, 3'b011};
            tetrisPkg::PieceL:      pattern = {3'b000, 3'b011, 3'b001, 3'b001};
            tetrisPkg::PieceRevL:   pattern = {3'b000, 3'b011, 3'b010, 3'b010};
            tetrisPkg::PieceS:      pattern = {3'b000, 3'b000, 3'b011, 3'b110};
            tetrisPkg::PieceZ:      pattern = {3'b000, 3'b000, 3'b110, 3'b011};
            tetrisPkg::PieceT:      pattern = {3'b000, 3'b000, 3'b111, 3'b010};
            default:                pattern = '0;
        endcase

        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 3; c++) begin
                cellRow = int'(row) + r;
                cellCol = int'(col) + c;
                if (pattern[r][c] && cellRow < tetrisPkg::BoardRows &&
                    cellCol < tetrisPkg::BoardCols) begin
                    mask[cellRow][cellCol] = 1'b1;
                end
            end
        end
        return mask;
    endfunction

    assign curMask  = shapeMask(curType, curCol, blockY);
    assign nextMask = shapeMask(curType, curCol, blockY + 5'd1);

    // Next position must stay above the padding rows and miss settled cells
    assign canMove = ~|(nextMask & settled) &&
                     ~|nextMask[tetrisPkg::BoardRows-1:tetrisPkg::PlayRows];

    assign landed  = active && tick && !canMove;
    assign blocked = |(curMask & settled);  // Meaningful right after spawn

    always_comb begin
        overlay = settled;
        if (active) begin
            overlay = settled | curMask;
        end
    end

    always_ff @(posedge clk) begin
        if (spawn) begin
            curType <= pieceType;
            curCol  <= pieceCol;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blockY <= '0;
            active <= 1'b0;
        end else if (spawn) begin
            blockY <= '0;  // Enter at the top row
            active <= 1'b1;
        end else if (active && tick) begin
            if (canMove) begin
                blockY <= blockY + 5'd1;
            end else begin
                active <= 1'b0;  // Piece now lives in the settled board
            end
        end
    end

endmodule

//--- hw/pieceQueue.sv
`timescale 1ns/100ps

module pieceQueue (
    input  logic                clk,
    input  logic                rst,
    input  logic                pieceValid,
    input  tetrisPkg::pieceKind pieceType,
    input  tetrisPkg::colIndex  pieceCol,
    input  logic                pop,
    output logic                headValid,
    output tetrisPkg::pieceKind headType,
    output tetrisPkg::colIndex  headCol,
    output logic                pieceCredit
);

    tetrisPkg::pieceKind typeMem [tetrisPkg::PieceCredits];
    tetrisPkg::colIndex  colMem  [tetrisPkg::PieceCredits];

    logic [tetrisPkg::QueuePtrBits-1:0] wrPtr, rdPtr;
    logic [tetrisPkg::QueueCntBits-1:0] fill;
    logic                               doPop;

    // Circular pointer advance
    function automatic logic [tetrisPkg::QueuePtrBits-1:0] bump(
        input logic [tetrisPkg::QueuePtrBits-1:0] ptr
    );
        if (ptr == tetrisPkg::QueuePtrBits'(tetrisPkg::PieceCredits - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign headValid = (fill != '0);
    assign doPop     = pop && headValid;  // Ignore pops on an empty queue
    assign headType  = typeMem[rdPtr];
    assign headCol   = colMem[rdPtr];

    always_ff @(posedge clk) begin
        if (pieceValid) begin
            typeMem[wrPtr] <= pieceType;
            colMem[wrPtr]  <= pieceCol;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            fill        <= '0;
            pieceCredit <= 1'b0;
        end else begin
            pieceCredit <= doPop;  // One credit back per piece taken
            if (pieceValid) begin
                wrPtr <= bump(wrPtr);
            end
            if (doPop) begin
                rdPtr <= bump(rdPtr);
            end
            case ({pieceValid, doPop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // Push and pop together, or neither
            endcase
        end
    end

endmodule

//--- hw/tetrisPkg.sv
package tetrisPkg;

    // Board geometry
    localparam int BoardRows = 22;  // Rows 20 and 21 are padding below the floor
    localparam int PlayRows  = 20;  // Row 19 is the floor row
    localparam int BoardCols = 10;

    // Game timing
    localparam int DropPeriod = 4;  // Cycles between drop ticks

    // Credit channels
    localparam int PieceCredits  = 2;  // Queue depth and initial source credits
    localparam int ReportCredits = 2;  // Initial report credits held by the core

    // Derived widths
    localparam int QueuePtrBits  = $clog2(PieceCredits);
    localparam int QueueCntBits  = $clog2(PieceCredits + 1);
    localparam int DropCntBits   = $clog2(DropPeriod);
    localparam int ReportCntBits = $clog2(ReportCredits + 1);

    // Piece shapes
    typedef enum logic [2:0] {
        PieceLine   = 3'd0,
        PieceSquare = 3'd1,
        PieceL      = 3'd2,
        PieceRevL   = 3'd3,
        PieceS      = 3'd4,
        PieceZ      = 3'd5,
        PieceT      = 3'd6
    } pieceKind;

    typedef logic [4:0] rowIndex;  // Board row counted from the top
    typedef logic [3:0] colIndex;  // Anchor column of a piece

    // Row-major board indexed as board[row][col]
    typedef logic [BoardRows-1:0][BoardCols-1:0] boardArray;

endpackage

//--- hw/tetrisTop.sv
`timescale 1ns/100ps

module tetrisTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pieceValid,
    input  tetrisPkg::pieceKind  pieceType,
    input  tetrisPkg::colIndex   pieceCol,
    output logic                 pieceCredit,
    output logic                 reportValid,
    output logic [2:0]           reportCount,
    input  logic                 reportCredit,
    output tetrisPkg::boardArray board,
    output logic                 gameOver
);

    logic                 headValid;
    tetrisPkg::pieceKind  headType;
    tetrisPkg::colIndex   headCol;
    logic                 pop;
    logic                 spawn;
    logic                 tick;
    logic                 timerRun;
    logic                 landed;
    logic                 blocked;
    tetrisPkg::boardArray settled;
    tetrisPkg::boardArray clearedBoard;
    logic                 clearStart;
    logic                 clearDone;
    logic [2:0]           clearCount;

    pieceQueue uQueue (
        .clk, .rst, .pieceValid, .pieceType, .pieceCol, .pop,
        .headValid, .headType, .headCol, .pieceCredit
    );

    dropTimer uTimer (
        .clk, .rst, .run(timerRun), .spawn, .tick
    );

    moveDown uMove (
        .clk, .rst, .spawn, .tick,
        .pieceType(headType), .pieceCol(headCol),
        .settled, .overlay(board), .landed, .blocked
    );

    lineClear uClear (
        .clk, .rst, .start(clearStart), .boardIn(settled),
        .boardOut(clearedBoard), .clearCount, .clearDone
    );

    gameControl uCtrl (
        .clk, .rst, .headValid, .pop, .spawn, .landed, .blocked,
        .overlay(board), .clearDone, .clearCount, .clearedBoard, .clearStart,
        .settled, .reportValid, .reportCount, .reportCredit, .gameOver, .timerRun
    );

endmodule

//--- verif/tetrisTb.sv
`timescale 1ns/100ps

module tetrisTb;

    localparam int TimeoutCycles = 500;
    localparam int QuietCycles   = 300;

    typedef logic [tetrisPkg::BoardCols-1:0] boardRow;

    logic                 clk;
    logic                 rst;
    logic                 pieceValid;
    tetrisPkg::pieceKind  pieceType;
    tetrisPkg::colIndex   pieceCol;
    logic                 pieceCredit;
    logic                 reportValid;
    logic [2:0]           reportCount;
    logic                 reportCredit;
    tetrisPkg::boardArray board;
    logic                 gameOver;

    tetrisPkg::pieceKind tblType[$];   // Piece table
    tetrisPkg::colIndex  tblCol[$];
    logic [2:0]          tblCount[$];
    boardRow             tblRow[$];    // Floor row once the piece has settled

    logic [2:0] gotCount[$];  // Reports caught by the monitor
    boardRow    gotRow[$];

    int          heldCredits;     // Piece credits held by the source
    int          pendingReturns;  // Report credits still to hand back
    int          gapLeft;
    bit          gapArmed;
    bit          returnCredits;
    int          creditPulses;
    int          errors;
    int          testsPassed;
    int          testsFailed;
    int unsigned seed;

    tetrisTop dut (
        .clk, .rst, .pieceValid, .pieceType, .pieceCol, .pieceCredit,
        .reportValid, .reportCount, .reportCredit, .board, .gameOver
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs sampled on the falling edge
    always @(negedge clk) begin
        if (pieceCredit) begin
            heldCredits++;
            creditPulses++;
        end
        if (reportValid) begin
            gotCount.push_back(reportCount);
            gotRow.push_back(board[tetrisPkg::PlayRows-1]);
            if (returnCredits) begin
                pendingReturns++;
            end
        end
    end

    // Report credit return after a random gap
    initial begin : creditReturn
        seed = 32'hbf2a;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            #5;
            reportCredit = 1'b0;
            if (!gapArmed && pendingReturns > 0) begin
                gapLeft  = $urandom % 4;
                gapArmed = 1'b1;
            end
            if (gapArmed) begin
                if (gapLeft == 0) begin
                    reportCredit = 1'b1;
                    pendingReturns--;
                    gapArmed = 1'b0;
                end else begin
                    gapLeft--;
                end
            end
        end
    end

    task automatic nextSample();
        @(negedge clk);
        #1;  // Past the monitor's updates
    endtask

    task automatic applyReset();
        @(posedge clk);
        #5;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        heldCredits    = tetrisPkg::PieceCredits;
        pendingReturns = 0;
        gapArmed       = 1'b0;
        gotCount.delete();
        gotRow.delete();
        @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    task automatic checkCount(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkRow(input string name, input boardRow got, input boardRow exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%03h expected 0x%03h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d error(s)", name, errors - errorsBefore);
        end
    endtask

    task automatic sendPiece(input tetrisPkg::pieceKind kind, input tetrisPkg::colIndex col,
                             output bit sent);
        int waited;

        waited = 0;
        sent   = 1'b0;
        while (heldCredits == 0 && waited < TimeoutCycles) begin
            nextSample();
            waited++;
        end
        if (heldCredits == 0) begin
            $display("No piece credit came back within %0d cycles", TimeoutCycles);
            errors++;
            return;
        end
        @(posedge clk);
        #5;
        pieceValid = 1'b1;
        pieceType  = kind;
        pieceCol   = col;
        heldCredits--;
        sent = 1'b1;
        @(posedge clk);
        #5;
        pieceValid = 1'b0;
    endtask

    task automatic waitReport(input int limit, output bit seen);
        int waited;

        waited = 0;
        while (gotCount.size() == 0 && waited < limit) begin
            nextSample();
            waited++;
        end
        seen = (gotCount.size() != 0);
    endtask

    task automatic addPiece(input tetrisPkg::pieceKind kind, input tetrisPkg::colIndex col,
                            input logic [2:0] count, input boardRow row);
        tblType.push_back(kind);
        tblCol.push_back(col);
        tblCount.push_back(count);
        tblRow.push_back(row);
    endtask

    task automatic buildTable();
        addPiece(tetrisPkg::PieceSquare, 4'd0, 3'd0, 10'h003);  // Stacking
        addPiece(tetrisPkg::PieceSquare, 4'd0, 3'd0, 10'h003);
        addPiece(tetrisPkg::PieceT,      4'd3, 3'd0, 10'h03B);
        addPiece(tetrisPkg::PieceSquare, 4'd0, 3'd0, 10'h003);  // Two rows filled
        addPiece(tetrisPkg::PieceSquare, 4'd2, 3'd0, 10'h00F);
        addPiece(tetrisPkg::PieceSquare, 4'd4, 3'd0, 10'h03F);
        addPiece(tetrisPkg::PieceSquare, 4'd6, 3'd0, 10'h0FF);
        addPiece(tetrisPkg::PieceSquare, 4'd8, 3'd2, 10'h000);
        addPiece(tetrisPkg::PieceLine,   4'd9, 3'd0, 10'h200);  // One row with mixed shapes
        addPiece(tetrisPkg::PieceL,      4'd0, 3'd0, 10'h203);
        addPiece(tetrisPkg::PieceRevL,   4'd7, 3'd0, 10'h383);
        addPiece(tetrisPkg::PieceLine,   4'd2, 3'd0, 10'h387);
        addPiece(tetrisPkg::PieceSquare, 4'd3, 3'd0, 10'h39F);
        addPiece(tetrisPkg::PieceSquare, 4'd5, 3'd1, 10'h37D);
        for (int i = 0; i < 5; i++) begin
            addPiece(tetrisPkg::PieceLine, 4'd0, 3'd0, 10'h001);  // Column 0 tower
        end
    endtask

    task automatic runPieces(input int first, input int last);
        bit sent;
        bit seen;
        int mark;

        for (int i = first; i <= last; i++) begin
            mark = errors;
            sendPiece(tblType[i], tblCol[i], sent);
            if (sent) begin
                waitReport(TimeoutCycles, seen);
                if (!seen) begin
                    $display("No report for piece %0d within %0d cycles", i, TimeoutCycles);
                    errors++;
                end else begin
                    checkCount("reportCount", gotCount.pop_front(), tblCount[i]);
                    checkRow("board[19]", gotRow.pop_front(), tblRow[i]);
                end
            end
            finishTest($sformatf("piece %0d type %0d col %0d", i, tblType[i], tblCol[i]), mark);
        end
    endtask

    initial begin : mainSeq
        int mark;
        int waited;
        int pulsesBefore;
        bit seen;
        bit sent;

        rst            = 1'b1;
        pieceValid     = 1'b0;
        pieceType      = tetrisPkg::PieceLine;
        pieceCol       = '0;
        reportCredit   = 1'b0;
        heldCredits    = tetrisPkg::PieceCredits;
        pendingReturns = 0;
        gapLeft        = 0;
        gapArmed       = 1'b0;
        returnCredits  = 1'b1;
        creditPulses   = 0;
        errors         = 0;
        testsPassed    = 0;
        testsFailed    = 0;
        buildTable();
        applyReset();

        mark = errors;
        for (int r = 0; r < tetrisPkg::BoardRows; r++) begin
            checkRow($sformatf("board[%0d]", r), board[r], '0);
        end
        checkFlag("gameOver", gameOver, 1'b0);
        waitReport(50, seen);
        checkFlag("reportValid", seen, 1'b0);
        finishTest("reset state", mark);

        runPieces(0, 2);
        mark = errors;
        for (int r = 16; r < 19; r++) begin
            checkRow($sformatf("board[%0d]", r), board[r], (r == 18) ? 10'h013 : 10'h003);
        end
        finishTest("stack shape", mark);
        applyReset();
        runPieces(3, 13);

        // Hold back report credits
        applyReset();
        returnCredits = 1'b0;
        runPieces(0, 1);
        mark = errors;
        sendPiece(tetrisPkg::PieceSquare, 4'd0, sent);
        waitReport(QuietCycles, seen);
        checkFlag("reportValid", seen, 1'b0);
        sendPiece(tetrisPkg::PieceSquare, 4'd0, sent);
        sendPiece(tetrisPkg::PieceSquare, 4'd0, sent);
        pulsesBefore = creditPulses;
        repeat (QuietCycles) nextSample();
        checkFlag("pieceCredit", creditPulses != pulsesBefore, 1'b0);
        pendingReturns = 1;  // Release a single credit
        waitReport(TimeoutCycles, seen);
        if (!seen) begin
            $display("No report came after one credit was returned");
            errors++;
        end else begin
            checkCount("reportCount", gotCount.pop_front(), 3'd0);
            checkRow("board[19]", gotRow.pop_front(), 10'h003);
        end
        repeat (QuietCycles) nextSample();
        checkFlag("reportValid", gotCount.size() != 0, 1'b0);
        finishTest("report back-pressure", mark);

        // Tower at column 0 until a spawn overlaps
        applyReset();
        returnCredits = 1'b1;
        runPieces(14, 18);
        mark = errors;
        pulsesBefore = creditPulses;
        sendPiece(tetrisPkg::PieceLine, 4'd0, sent);
        waited = 0;
        while (!gameOver && waited < TimeoutCycles) begin
            nextSample();
            waited++;
        end
        if (!gameOver) begin
            $display("gameOver did not rise after a blocked spawn");
            errors++;
        end
        sendPiece(tetrisPkg::PieceLine, 4'd0, sent);
        repeat (QuietCycles) nextSample();
        checkFlag("gameOver", gameOver, 1'b1);
        checkFlag("reportValid", gotCount.size() != 0, 1'b0);
        checkFlag("pieceCredit", (creditPulses - pulsesBefore) != 1, 1'b0);  // Only the blocked one
        finishTest("game over", mark);

        errors += dut.props.assertFails;
        $display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tetrisTop_props.sv
`timescale 1ns/100ps

module tetrisTop_props (
    input logic       clk,
    input logic       rst,
    input logic       pieceValid,
    input logic       pieceCredit,
    input logic       reportValid,
    input logic [2:0] reportCount,
    input logic       reportCredit,
    input logic       gameOver
);

    int   assertFails = 0;
    int   sourceCredits;  // Free queue slots as seen by the source
    int   coreCredits;    // Report credits the core should hold
    logic pieceSeen;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sourceCredits <= tetrisPkg::PieceCredits;
            coreCredits   <= tetrisPkg::ReportCredits;
            pieceSeen     <= 1'b0;
        end else begin
            sourceCredits <= sourceCredits - int'(pieceValid) + int'(pieceCredit);
            coreCredits   <= coreCredits - int'(reportValid) + int'(reportCredit);
            if (pieceValid) begin
                pieceSeen <= 1'b1;
            end
        end
    end

    queueNotFull: assert property (@(posedge clk) disable iff (rst)
        pieceValid |-> sourceCredits > 0)
        else begin
            assertFails++;
            $error("piece pushed while the queue is full");
        end

    reportHasCredit: assert property (@(posedge clk) disable iff (rst)
        reportValid |-> coreCredits > 0)
        else begin
            assertFails++;
            $error("report sent with no credit");
        end

    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        !pieceSeen |-> !reportValid && !gameOver)
        else begin
            assertFails++;
            $error("report or game over before any piece");
        end

    countInRange: assert property (@(posedge clk) disable iff (rst)
        reportValid |-> reportCount <= 3'd4)
        else begin
            assertFails++;
            $error("report count above four");
        end

endmodule

bind tetrisTop tetrisTop_props props (
    .clk, .rst, .pieceValid, .pieceCredit, .reportValid,
    .reportCount, .reportCredit, .gameOver
);

//--- verilog.f
hw/tetrisPkg.sv
hw/pieceQueue.sv
hw/dropTimer.sv
hw/moveDown.sv
hw/lineClear.sv
hw/gameControl.sv
hw/tetrisTop.sv
verif/tetrisTop_props.sv
verif/tetrisTb.sv
